//--- logic/rx_trn_pkg.sv
package rx_trn_pkg;

  // ------------------------------------------------------------
  // TRN bus vectors
  // ------------------------------------------------------------
  typedef logic [127:0] trn_data_t;     // Dword 0 in bits 127:96
  typedef logic [63:0]  trn_half_t;
  typedef logic [1:0]   trn_rem_t;      // 11 = 4 DW ... 00 = 1 DW

  // TLP header fields
  typedef logic [9:0]   tlp_len_t;      // 0 encodes 1024 DW
  typedef logic [6:0]   tlp_fmt_type_t; // Bit 5 4DW header, bit 6 has data
  typedef logic [10:0]  dw_count_t;

  typedef enum logic [1:0] {
    ST_IDLE     = 2'b00,
    ST_SHIFT    = 2'b01,
    ST_THROTTLE = 2'b10
  } destraddle_state_e;

  // ------------------------------------------------------------
  // Dword count helpers
  // ------------------------------------------------------------
  localparam dw_count_t DW_PER_BEAT  = 11'd4;
  localparam dw_count_t HDR_DW_SHORT = 11'd3;
  localparam dw_count_t HDR_DW_LONG  = 11'd4;
  localparam dw_count_t LEN_MAX_DW   = 11'd1024; // Length field of zero

  // Error flag positions
  localparam int ERR_FWD  = 2;
  localparam int ERR_ECRC = 1;
  localparam int ERR_DSC  = 0;

endpackage

//--- logic/rx_destraddler.sv
`timescale 1ns/1ns

module rx_destraddler #(
  parameter int bar_width = 8
) (
  input  logic                      com_iclk,
  input  logic                      com_sysrst,

  // Link side
  input  rx_trn_pkg::trn_data_t     trn_rd_i,
  input  logic                      trn_rsof_i,
  input  logic                      trn_reof_i,
  input  rx_trn_pkg::trn_rem_t      trn_rrem_i,
  input  logic                      trn_rsrc_rdy_i,
  input  logic                      trn_rsrc_dsc_i,
  input  logic                      trn_rerrfwd_i,
  input  logic                      trn_recrc_err_i,
  input  logic [bar_width-1:0]      trn_rbar_hit_i,
  output logic                      trn_rdst_rdy_o,

  // Realigned side
  input  logic                      user_dst_rdy_i,
  output rx_trn_pkg::trn_data_t     trn_rd_o,
  output logic                      trn_rsof_o,
  output logic                      trn_reof_o,
  output rx_trn_pkg::trn_rem_t      trn_rrem_o,
  output logic                      trn_rsrc_rdy_o,
  output logic                      trn_rsrc_dsc_o,
  output logic                      trn_rerrfwd_o,
  output logic                      trn_recrc_err_o,
  output logic [bar_width-1:0]      trn_rbar_hit_o
);

  rx_trn_pkg::destraddle_state_e state_q;

  // Held copy of the trailing half-beat and its side-band
  rx_trn_pkg::trn_half_t half_q;
  logic                  sof_q;
  logic                  rrem0_q;
  logic                  errfwd_q;
  logic                  ecrc_q;
  logic [bar_width-1:0]  bar_q;

  logic acc;        // Link beat accepted
  logic ends_upper; // Packet ends within bits 127:64

  assign trn_rdst_rdy_o = user_dst_rdy_i && (state_q != rx_trn_pkg::ST_THROTTLE);
  assign acc            = trn_rsrc_rdy_i && trn_rdst_rdy_o;
  assign ends_upper     = trn_reof_i && !trn_rrem_i[1];

  // ------------------------------------------------------------
  // Half-beat storage
  // ------------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (acc) begin
      half_q   <= trn_rd_i[63:0];
      sof_q    <= trn_rsof_i;     // Set when a packet starts at bit 63
      rrem0_q  <= trn_rrem_i[0];
      errfwd_q <= trn_rerrfwd_i;
      ecrc_q   <= trn_recrc_err_i;
      bar_q    <= trn_rbar_hit_i;
    end
  end

  // ------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      state_q <= rx_trn_pkg::ST_IDLE;
    end else if (trn_rsrc_dsc_i) begin
      state_q <= rx_trn_pkg::ST_IDLE; // Discontinue drops any shift
    end else begin
      case (state_q)
        rx_trn_pkg::ST_IDLE: begin
          // Unaligned start, alone or straddled behind an aligned tail
          if (acc && trn_rsof_i && !trn_rrem_i[1])
            state_q <= rx_trn_pkg::ST_SHIFT;
        end
        rx_trn_pkg::ST_SHIFT: begin
          if (acc && trn_reof_i) begin
            if (!ends_upper)
              state_q <= rx_trn_pkg::ST_THROTTLE; // Tail spills into lower half
            else if (!trn_rsof_i)
              state_q <= rx_trn_pkg::ST_IDLE;
          end
        end
        default: begin
          if (user_dst_rdy_i)
            state_q <= rx_trn_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Realigned outputs
  // ------------------------------------------------------------
  always_comb begin
    trn_rd_o        = trn_rd_i;
    trn_rsof_o      = trn_rsof_i;
    trn_reof_o      = trn_reof_i;
    trn_rrem_o      = trn_rrem_i;
    trn_rsrc_rdy_o  = trn_rsrc_rdy_i;
    trn_rsrc_dsc_o  = trn_rsrc_dsc_i;
    trn_rerrfwd_o   = trn_rerrfwd_i;
    trn_recrc_err_o = trn_recrc_err_i;
    trn_rbar_hit_o  = trn_rbar_hit_i;

    case (state_q)
      rx_trn_pkg::ST_IDLE: begin
        if (trn_rsof_i && !trn_rrem_i[1]) begin
          if (trn_reof_i) begin
            // Only the aligned tail of the straddle leaves now
            trn_rd_o   = {trn_rd_i[127:64], rx_trn_pkg::trn_half_t'('0)};
            trn_rsof_o = 1'b0;
          end else begin
            trn_rsrc_rdy_o = 1'b0; // Start at bit 63, hold back one beat
            trn_rsof_o     = 1'b0;
          end
        end
      end

      rx_trn_pkg::ST_SHIFT: begin
        // Stored half on top, live upper half below
        trn_rd_o       = {half_q, trn_rd_i[127:64]};
        trn_rsof_o     = sof_q;
        trn_rbar_hit_o = bar_q;
        if (ends_upper) begin
          trn_reof_o = 1'b1;
          trn_rrem_o = {1'b1, trn_rrem_i[0]};
        end else begin
          trn_reof_o = 1'b0; // Either mid-packet or tail still stored
          trn_rrem_o = 2'b11;
        end
      end

      default: begin
        // Flush the stored tail alone
        trn_rd_o        = {half_q, rx_trn_pkg::trn_half_t'('0)};
        trn_rsof_o      = 1'b0;
        trn_reof_o      = 1'b1;
        trn_rrem_o      = {1'b0, rrem0_q};
        trn_rsrc_rdy_o  = 1'b1;
        trn_rerrfwd_o   = errfwd_q;
        trn_recrc_err_o = ecrc_q;
        trn_rbar_hit_o  = bar_q;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  a_throttle_one_cycle: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    (state_q == rx_trn_pkg::ST_THROTTLE && user_dst_rdy_i)
      |=> state_q != rx_trn_pkg::ST_THROTTLE);

  a_no_ready_under_backpressure: assert property (@(posedge com_iclk)
    disable iff (com_sysrst) !user_dst_rdy_i |-> !trn_rdst_rdy_o);

endmodule

//--- logic/rx_tlp_header_decode.sv
`timescale 1ns/1ns

module rx_tlp_header_decode #(
  parameter int bar_width = 8
) (
  input  logic                          com_iclk,
  input  logic                          com_sysrst,
  input  rx_trn_pkg::trn_data_t         trn_rd_i,
  input  logic                          trn_rsof_i,
  input  logic                          trn_rsrc_rdy_i,
  input  logic                          user_dst_rdy_i,
  input  logic [bar_width-1:0]          trn_rbar_hit_i,
  output rx_trn_pkg::tlp_fmt_type_t     hdr_fmt_type_o,
  output rx_trn_pkg::tlp_len_t          hdr_len_o,
  output logic [bar_width-1:0]          hdr_bar_o
);

  logic sof_xfer;

  // Header dword 0 sits in 127:96 on every realigned sof beat
  assign sof_xfer = trn_rsof_i && trn_rsrc_rdy_i && user_dst_rdy_i;

  // ------------------------------------------------------------
  // Header capture
  // ------------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      hdr_fmt_type_o <= '0;
      hdr_len_o      <= '0;
      hdr_bar_o      <= '0;
    end else if (sof_xfer) begin
      hdr_fmt_type_o <= trn_rd_i[126:120]; // Fmt and type
      hdr_len_o      <= trn_rd_i[105:96];  // Length in dwords
      hdr_bar_o      <= trn_rbar_hit_i;
    end
  end

endmodule

//--- logic/rx_tlp_status_track.sv
`timescale 1ns/1ns

module rx_tlp_status_track (
  input  logic                      com_iclk,
  input  logic                      com_sysrst,
  input  logic                      trn_rsof_i,
  input  logic                      trn_reof_i,
  input  rx_trn_pkg::trn_rem_t      trn_rrem_i,
  input  logic                      trn_rsrc_rdy_i,
  input  logic                      trn_rsrc_dsc_i,
  input  logic                      user_dst_rdy_i,
  input  logic                      trn_rerrfwd_i,
  input  logic                      trn_recrc_err_i,
  output rx_trn_pkg::dw_count_t     sts_dw_count_o,
  output logic [2:0]                sts_err_o,
  output logic                      sts_done_o
);

  logic                  xfer;
  logic                  dsc_evt;
  logic                  open_q;    // Packet in flight
  rx_trn_pkg::dw_count_t beat_dw;
  logic [2:0]            err_new;

  assign xfer    = trn_rsrc_rdy_i && user_dst_rdy_i;
  assign dsc_evt = trn_rsrc_dsc_i && open_q;
  assign beat_dw = trn_reof_i ? rx_trn_pkg::dw_count_t'(trn_rrem_i) + 11'd1
                              : rx_trn_pkg::DW_PER_BEAT;

  always_comb begin
    err_new                       = '0;
    err_new[rx_trn_pkg::ERR_FWD]  = xfer && trn_rerrfwd_i;
    err_new[rx_trn_pkg::ERR_ECRC] = xfer && trn_recrc_err_i;
    err_new[rx_trn_pkg::ERR_DSC]  = dsc_evt;
  end

  // ------------------------------------------------------------
  // Per-TLP counters
  // ------------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      open_q         <= 1'b0;
      sts_done_o     <= 1'b0;
      sts_dw_count_o <= '0;
      sts_err_o      <= '0;
    end else begin
      sts_done_o <= (xfer && trn_reof_i) || dsc_evt;
      if (xfer && trn_rsof_i) begin
        open_q         <= !trn_reof_i;
        sts_dw_count_o <= beat_dw;     // Fresh packet
        sts_err_o      <= err_new;
      end else if (xfer && open_q) begin
        open_q         <= !trn_reof_i && !dsc_evt;
        sts_dw_count_o <= sts_dw_count_o + beat_dw;
        sts_err_o      <= sts_err_o | err_new;
      end else if (dsc_evt) begin
        open_q    <= 1'b0;
        sts_err_o <= sts_err_o | err_new;
      end else if (sts_done_o) begin
        sts_dw_count_o <= '0;          // Cleared once reported
        sts_err_o      <= '0;
      end
    end
  end

  a_eof_needs_open: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    (xfer && trn_reof_i && !trn_rsof_i) |-> open_q);

endmodule

//--- logic/rx_tlp_report.sv
`timescale 1ns/1ns

module rx_tlp_report #(
  parameter int bar_width = 8
) (
  input  logic                          com_iclk,
  input  logic                          com_sysrst,
  input  rx_trn_pkg::tlp_fmt_type_t     hdr_fmt_type_i,
  input  rx_trn_pkg::tlp_len_t          hdr_len_i,
  input  logic [bar_width-1:0]          hdr_bar_i,
  input  rx_trn_pkg::dw_count_t         sts_dw_count_i,
  input  logic [2:0]                    sts_err_i,
  input  logic                          sts_done_i,
  output logic                          rpt_valid_o,
  output rx_trn_pkg::tlp_fmt_type_t     rpt_fmt_type_o,
  output rx_trn_pkg::tlp_len_t          rpt_len_o,
  output logic [bar_width-1:0]          rpt_bar_o,
  output rx_trn_pkg::dw_count_t         rpt_dw_count_o,
  output logic [2:0]                    rpt_err_o,
  output logic                          rpt_len_mismatch_o
);

  rx_trn_pkg::dw_count_t hdr_dw;
  rx_trn_pkg::dw_count_t data_dw;
  rx_trn_pkg::dw_count_t exp_dw;

  // Expected total from the header
  assign hdr_dw  = hdr_fmt_type_i[5] ? rx_trn_pkg::HDR_DW_LONG : rx_trn_pkg::HDR_DW_SHORT;
  assign data_dw = !hdr_fmt_type_i[6]  ? '0 :
                   (hdr_len_i == '0)   ? rx_trn_pkg::LEN_MAX_DW :
                                         rx_trn_pkg::dw_count_t'(hdr_len_i);
  assign exp_dw  = hdr_dw + data_dw;

  always_ff @(posedge com_iclk) begin
    if (com_sysrst)
      rpt_valid_o <= 1'b0;
    else
      rpt_valid_o <= sts_done_i;
  end

  // Record holds until the next done pulse
  always_ff @(posedge com_iclk) begin
    if (sts_done_i) begin
      rpt_fmt_type_o     <= hdr_fmt_type_i;
      rpt_len_o          <= hdr_len_i;
      rpt_bar_o          <= hdr_bar_i;
      rpt_dw_count_o     <= sts_dw_count_i;
      rpt_err_o          <= sts_err_i;
      rpt_len_mismatch_o <= !sts_err_i[rx_trn_pkg::ERR_DSC] && (exp_dw != sts_dw_count_i);
    end
  end

endmodule

//--- logic/rx_destraddle_top.sv
`timescale 1ns/1ns

module rx_destraddle_top #(
  parameter int bar_width = 8
) (
  input  logic                          com_iclk,
  input  logic                          com_sysrst,

  // ------------------------------------------------------------
  // Link side
  // ------------------------------------------------------------
  input  rx_trn_pkg::trn_data_t         trn_rd_i,
  input  logic                          trn_rsof_i,
  input  logic                          trn_reof_i,
  input  rx_trn_pkg::trn_rem_t          trn_rrem_i,
  input  logic                          trn_rsrc_rdy_i,
  input  logic                          trn_rsrc_dsc_i,
  input  logic                          trn_rerrfwd_i,
  input  logic                          trn_recrc_err_i,
  input  logic [bar_width-1:0]          trn_rbar_hit_i,
  output logic                          trn_rdst_rdy_o,

  // ------------------------------------------------------------
  // User side
  // ------------------------------------------------------------
  input  logic                          user_dst_rdy_i,
  output rx_trn_pkg::trn_data_t         trn_rd_o,
  output logic                          trn_rsof_o,
  output logic                          trn_reof_o,
  output rx_trn_pkg::trn_rem_t          trn_rrem_o,
  output logic                          trn_rsrc_rdy_o,
  output logic                          trn_rsrc_dsc_o,
  output logic                          trn_rerrfwd_o,
  output logic                          trn_recrc_err_o,
  output logic [bar_width-1:0]          trn_rbar_hit_o,

  // Per-TLP report
  output logic                          rpt_valid_o,
  output rx_trn_pkg::tlp_fmt_type_t     rpt_fmt_type_o,
  output rx_trn_pkg::tlp_len_t          rpt_len_o,
  output logic [bar_width-1:0]          rpt_bar_o,
  output rx_trn_pkg::dw_count_t         rpt_dw_count_o,
  output logic [2:0]                    rpt_err_o,
  output logic                          rpt_len_mismatch_o
);

  rx_trn_pkg::tlp_fmt_type_t hdr_fmt_type;
  rx_trn_pkg::tlp_len_t      hdr_len;
  logic [bar_width-1:0]      hdr_bar;
  rx_trn_pkg::dw_count_t     sts_dw_count;
  logic [2:0]                sts_err_flags; // Errfwd, ECRC, discontinue
  logic                      sts_done;

  rx_destraddler #(.bar_width(bar_width)) u_destraddler (
    .com_iclk        (com_iclk),
    .com_sysrst      (com_sysrst),
    .trn_rd_i        (trn_rd_i),
    .trn_rsof_i      (trn_rsof_i),
    .trn_reof_i      (trn_reof_i),
    .trn_rrem_i      (trn_rrem_i),
    .trn_rsrc_rdy_i  (trn_rsrc_rdy_i),
    .trn_rsrc_dsc_i  (trn_rsrc_dsc_i),
    .trn_rerrfwd_i   (trn_rerrfwd_i),
    .trn_recrc_err_i (trn_recrc_err_i),
    .trn_rbar_hit_i  (trn_rbar_hit_i),
    .trn_rdst_rdy_o  (trn_rdst_rdy_o),
    .user_dst_rdy_i  (user_dst_rdy_i),
    .trn_rd_o        (trn_rd_o),
    .trn_rsof_o      (trn_rsof_o),
    .trn_reof_o      (trn_reof_o),
    .trn_rrem_o      (trn_rrem_o),
    .trn_rsrc_rdy_o  (trn_rsrc_rdy_o),
    .trn_rsrc_dsc_o  (trn_rsrc_dsc_o),
    .trn_rerrfwd_o   (trn_rerrfwd_o),
    .trn_recrc_err_o (trn_recrc_err_o),
    .trn_rbar_hit_o  (trn_rbar_hit_o)
  );

  // Both side blocks watch the realigned stream
  rx_tlp_header_decode #(.bar_width(bar_width)) u_header_decode (
    .com_iclk       (com_iclk),
    .com_sysrst     (com_sysrst),
    .trn_rd_i       (trn_rd_o),
    .trn_rsof_i     (trn_rsof_o),
    .trn_rsrc_rdy_i (trn_rsrc_rdy_o),
    .user_dst_rdy_i (user_dst_rdy_i),
    .trn_rbar_hit_i (trn_rbar_hit_o),
    .hdr_fmt_type_o (hdr_fmt_type),
    .hdr_len_o      (hdr_len),
    .hdr_bar_o      (hdr_bar)
  );

  rx_tlp_status_track u_status_track (
    .com_iclk        (com_iclk),
    .com_sysrst      (com_sysrst),
    .trn_rsof_i      (trn_rsof_o),
    .trn_reof_i      (trn_reof_o),
    .trn_rrem_i      (trn_rrem_o),
    .trn_rsrc_rdy_i  (trn_rsrc_rdy_o),
    .trn_rsrc_dsc_i  (trn_rsrc_dsc_o),
    .user_dst_rdy_i  (user_dst_rdy_i),
    .trn_rerrfwd_i   (trn_rerrfwd_o),
    .trn_recrc_err_i (trn_recrc_err_o),
    .sts_dw_count_o  (sts_dw_count),
    .sts_err_o       (sts_err_flags),
    .sts_done_o      (sts_done)
  );

  rx_tlp_report #(.bar_width(bar_width)) u_report (
    .com_iclk           (com_iclk),
    .com_sysrst         (com_sysrst),
    .hdr_fmt_type_i     (hdr_fmt_type),
    .hdr_len_i          (hdr_len),
    .hdr_bar_i          (hdr_bar),
    .sts_dw_count_i     (sts_dw_count),
    .sts_err_i          (sts_err_flags),
    .sts_done_i         (sts_done),
    .rpt_valid_o        (rpt_valid_o),
    .rpt_fmt_type_o     (rpt_fmt_type_o),
    .rpt_len_o          (rpt_len_o),
    .rpt_bar_o          (rpt_bar_o),
    .rpt_dw_count_o     (rpt_dw_count_o),
    .rpt_err_o          (rpt_err_o),
    .rpt_len_mismatch_o (rpt_len_mismatch_o)
  );

endmodule

//--- testbench/rx_destraddle_tb.sv
`timescale 1ns/1ns

module rx_destraddle_tb;

  localparam int BAR_W      = 8;
  localparam int MEM_DEPTH  = 64;
  localparam int WAIT_LIMIT = 100;

  logic                 com_iclk;
  logic                 com_sysrst;
  logic [127:0]         trn_rd_i;
  logic                 trn_rsof_i;
  logic                 trn_reof_i;
  logic [1:0]           trn_rrem_i;
  logic                 trn_rsrc_rdy_i;
  logic                 trn_rsrc_dsc_i;
  logic                 trn_rerrfwd_i;
  logic                 trn_recrc_err_i;
  logic [BAR_W-1:0]     trn_rbar_hit_i;
  logic                 trn_rdst_rdy_o;
  logic                 user_dst_rdy_i;
  logic [127:0]         trn_rd_o;
  logic                 trn_rsof_o;
  logic                 trn_reof_o;
  logic [1:0]           trn_rrem_o;
  logic                 trn_rsrc_rdy_o;
  logic                 trn_rsrc_dsc_o;
  logic                 trn_rerrfwd_o;
  logic                 trn_recrc_err_o;
  logic [BAR_W-1:0]     trn_rbar_hit_o;
  logic                 rpt_valid_o;
  logic [6:0]           rpt_fmt_type_o;
  logic [9:0]           rpt_len_o;
  logic [BAR_W-1:0]     rpt_bar_o;
  logic [10:0]          rpt_dw_count_o;
  logic [2:0]           rpt_err_o;
  logic                 rpt_len_mismatch_o;

  // Record fields kind, bar, flags, pad and four dwords
  logic [159:0] mem [0:MEM_DEPTH-1];
  logic [159:0] exp_beats[$];
  logic [159:0] exp_rpts[$];
  integer       seed;
  int           errors;
  int           checks;
  int           pass1_errors;
  int           throttle_cycles;
  bit           bp_en;
  bit           timed_out;

  rx_destraddle_top #(.bar_width(BAR_W)) uut (.*);

  initial begin
    com_iclk = 1'b0;
    forever #2 com_iclk = ~com_iclk;
  end

  // User back-pressure low about one cycle in four
  always @(posedge com_iclk) begin
    #1;
    if (bp_en)
      user_dst_rdy_i <= ($random(seed) & 3) != 0;
    else
      user_dst_rdy_i <= 1'b1;
  end

  task automatic check_field(input string name, input logic [127:0] expv,
                             input logic [127:0] actv);
    checks++;
    if (expv !== actv) begin
      errors++;
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expv, actv);
    end
  endtask

  // ------------------------------------------------------------
  // Monitors sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge com_iclk) begin : beat_monitor
    logic [159:0] e;
    if (!com_sysrst && trn_rsrc_rdy_o && user_dst_rdy_i) begin
      if (exp_beats.size() == 0) begin
        errors++;
        $display("Realigned beat %0h arrived at %0t ns with none expected", trn_rd_o, $time);
      end else begin
        e = exp_beats.pop_front();
        check_field("trn_rd_o", e[127:0], trn_rd_o);
        check_field("trn_rsof_o", e[136], trn_rsof_o);
        check_field("trn_reof_o", e[137], trn_reof_o);
        check_field("trn_rrem_o", e[139:138], trn_rrem_o);
        check_field("trn_rsrc_dsc_o", e[140], trn_rsrc_dsc_o);
        check_field("trn_rerrfwd_o", e[141], trn_rerrfwd_o);
        check_field("trn_recrc_err_o", e[142], trn_recrc_err_o);
        check_field("trn_rbar_hit_o", e[151:144], trn_rbar_hit_o);
      end
    end
  end

  always @(negedge com_iclk) begin : report_monitor
    logic [159:0] e;
    if (!com_sysrst && rpt_valid_o) begin
      if (exp_rpts.size() == 0) begin
        errors++;
        $display("Report pulse at %0t ns with none expected", $time);
      end else begin
        e = exp_rpts.pop_front();
        check_field("rpt_fmt_type_o", e[102:96], rpt_fmt_type_o);
        check_field("rpt_len_o", e[73:64], rpt_len_o);
        check_field("rpt_dw_count_o", e[42:32], rpt_dw_count_o);
        check_field("rpt_bar_o", e[151:144], rpt_bar_o);
        check_field("rpt_err_o", e[138:136], rpt_err_o);
        check_field("rpt_len_mismatch_o", e[139], rpt_len_mismatch_o);
      end
    end
  end

  // Link ready under user back-pressure and the throttle cycles
  always @(negedge com_iclk) begin : ready_monitor
    if (!com_sysrst) begin
      if (!user_dst_rdy_i)
        check_field("trn_rdst_rdy_o", 1'b0, trn_rdst_rdy_o);
      else if (!trn_rdst_rdy_o)
        throttle_cycles++;
    end
  end

  task automatic drive_idle();
    trn_rd_i        = '0;
    trn_rsof_i      = 1'b0;
    trn_reof_i      = 1'b0;
    trn_rrem_i      = 2'b00;
    trn_rsrc_rdy_i  = 1'b0;
    trn_rsrc_dsc_i  = 1'b0;
    trn_rerrfwd_i   = 1'b0;
    trn_recrc_err_i = 1'b0;
    trn_rbar_hit_i  = '0;
  endtask

  // Idle records last one cycle and data records wait for acceptance
  task automatic drive_record(input logic [159:0] r);
    int waited;
    bit accepted;
    trn_rd_i        = r[127:0];
    trn_rsof_i      = r[136];
    trn_reof_i      = r[137];
    trn_rrem_i      = r[139:138];
    trn_rsrc_dsc_i  = r[140];
    trn_rerrfwd_i   = r[141];
    trn_recrc_err_i = r[142];
    trn_rsrc_rdy_i  = !r[143];
    trn_rbar_hit_i  = r[151:144];
    waited   = 0;
    accepted = 1'b0;
    if (r[143]) begin
      @(posedge com_iclk);
      #1;
    end else begin
      while (!accepted && waited < WAIT_LIMIT) begin
        @(negedge com_iclk);
        accepted = trn_rsrc_rdy_i && trn_rdst_rdy_o;
        @(posedge com_iclk);
        #1;
        waited++;
      end
      if (!accepted) begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout: input beat %0h was never accepted", r[127:0]);
      end
    end
  endtask

  task automatic wait_drain(input int test_no);
    int waited;
    waited = 0;
    while ((exp_beats.size() != 0 || exp_rpts.size() != 0) && waited < WAIT_LIMIT) begin
      @(negedge com_iclk);
      waited++;
    end
    if (exp_beats.size() != 0) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: realigned beat %0h of test %0d never appeared",
               exp_beats[0][127:0], test_no);
    end
    if (exp_rpts.size() != 0) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: report of length %0h in test %0d never appeared",
               exp_rpts[0][73:64], test_no);
    end
    exp_beats.delete();
    exp_rpts.delete();
    // Back to the drive point after the rising edge
    @(posedge com_iclk);
    #1;
  endtask

  // ------------------------------------------------------------
  // One walk through every test section of the data file
  // ------------------------------------------------------------
  task automatic run_pass(input bit with_bp);
    int           idx;
    int           sect_err;
    int           exp_throttles;
    bit           shifted;
    logic [159:0] inputs[$];
    bp_en      = with_bp;
    com_sysrst = 1'b1;
    repeat (3) @(posedge com_iclk);
    #1;
    com_sysrst = 1'b0;
    idx = 0;
    while (!timed_out && idx < MEM_DEPTH && mem[idx][159:152] != 8'h0f) begin
      sect_err        = errors;
      exp_throttles   = 0;
      shifted         = 1'b0;
      throttle_cycles = 0;
      inputs.delete();
      while (idx < MEM_DEPTH && mem[idx][159:152] != 8'h04) begin
        case (mem[idx][159:152])
          8'h01: begin
            inputs.push_back(mem[idx]);
            // A 3 or 4 dword tail of a shifted packet needs one flush cycle
            if (!mem[idx][143] && shifted && mem[idx][137] && mem[idx][139])
              exp_throttles++;
            if (mem[idx][140])
              shifted = 1'b0;
            else if (!mem[idx][143] && mem[idx][136] && !mem[idx][139])
              shifted = 1'b1;
            else if (!mem[idx][143] && mem[idx][137])
              shifted = 1'b0;
          end
          8'h02:   exp_beats.push_back(mem[idx]);
          default: exp_rpts.push_back(mem[idx]);
        endcase
        idx++;
      end
      foreach (inputs[i])
        if (!timed_out)
          drive_record(inputs[i]);
      drive_idle();
      if (!timed_out) begin
        wait_drain(mem[idx][143:136]);
        check_field("trn_rdst_rdy_o low cycles", exp_throttles, throttle_cycles);
      end
      $display("test %0d %s: %s, %0d errors", mem[idx][143:136],
               with_bp ? "with back-pressure" : "without back-pressure",
               (errors == sect_err) ? "passed" : "failed", errors - sect_err);
      idx++;
    end
  endtask

  initial begin
    seed            = 4;
    errors          = 0;
    checks          = 0;
    throttle_cycles = 0;
    timed_out       = 1'b0;
    bp_en           = 1'b0;
    user_dst_rdy_i  = 1'b1;
    com_sysrst      = 1'b1;
    drive_idle();
    $readmemh("testbench/rx_destraddle_testdata.txt", mem);
    run_pass(1'b0);
    pass1_errors = errors;
    if (!timed_out)
      run_pass(1'b1);
    $display("test 4 back-pressure replay: %s",
             (!timed_out && errors == pass1_errors) ? "passed" : "failed");
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- rx_destraddle.f
logic/rx_trn_pkg.sv
logic/rx_destraddler.sv
logic/rx_tlp_header_decode.sv
logic/rx_tlp_status_track.sv
logic/rx_tlp_report.sv
logic/rx_destraddle_top.sv
testbench/rx_destraddle_tb.sv

//--- testbench/rx_destraddle_testdata.txt
// kind_bar_flags_pad_dw0_dw1_dw2_dw3; kind 01 input, 02 realigned beat, 03 report, 04 test end
// flags 0 sof 1 eof 3:2 rem 4 dsc 5 errfwd 6 ecrc 7 idle; reports fmt, len, count, flags 2:0 err 3 mismatch
01_01_0b_00_00000001_aaaa0001_aaaa0002_00000000
01_02_0d_00_40000004_bbbb0001_bbbb0002_d0000000
01_02_0a_00_d0000001_d0000002_d0000003_00000000
02_01_0b_00_00000001_aaaa0001_aaaa0002_00000000
02_02_0d_00_40000004_bbbb0001_bbbb0002_d0000000
02_02_0a_00_d0000001_d0000002_d0000003_00000000
03_01_00_00_00000000_00000001_00000003_00000000
03_02_00_00_00000040_00000004_00000007_00000000
04_00_01_00_00000000_00000000_00000000_00000000
01_04_05_00_00000000_00000000_40000002_cccc0001
01_04_0a_00_cccc0002_d0000001_d0000002_00000000
01_08_05_00_00000000_00000000_20000001_eeee0001
01_08_06_00_eeee0002_eeee0003_00000000_00000000
02_04_0d_00_40000002_cccc0001_cccc0002_d0000001
02_04_02_00_d0000002_00000000_00000000_00000000
02_08_0f_00_20000001_eeee0001_eeee0002_eeee0003
03_04_00_00_00000040_00000002_00000005_00000000
03_08_00_00_00000020_00000001_00000004_00000000
04_00_02_00_00000000_00000000_00000000_00000000
01_10_0d_00_40000003_ab000001_ab000002_d1000001
01_10_07_00_d1000002_d1000003_00000002_f0000001
01_10_02_00_f0000002_00000000_00000000_00000000
02_10_0d_00_40000003_ab000001_ab000002_d1000001
02_10_06_00_d1000002_d1000003_00000000_00000000
02_10_0b_00_00000002_f0000001_f0000002_00000000
03_10_00_00_00000040_00000003_00000006_00000000
03_10_00_00_00000000_00000002_00000003_00000000
04_00_03_00_00000000_00000000_00000000_00000000
01_20_2f_00_40000001_12340001_12340002_da000001
01_20_0d_00_40000005_11110001_11110002_db000001
01_20_4e_00_db000002_db000003_db000004_db000005
01_20_0d_00_40000008_22220001_22220002_dc000001
01_20_90_00_00000000_00000000_00000000_00000000
02_20_2f_00_40000001_12340001_12340002_da000001
02_20_0d_00_40000005_11110001_11110002_db000001
02_20_4e_00_db000002_db000003_db000004_db000005
02_20_0d_00_40000008_22220001_22220002_dc000001
03_20_04_00_00000040_00000001_00000004_00000000
03_20_02_00_00000040_00000005_00000008_00000000
03_20_01_00_00000040_00000008_00000004_00000000
04_00_05_00_00000000_00000000_00000000_00000000
01_40_0f_00_40000004_33330001_33330002_dd000001
02_40_0f_00_40000004_33330001_33330002_dd000001
03_40_08_00_00000040_00000004_00000004_00000000
04_00_06_00_00000000_00000000_00000000_00000000
0f_00_00_00_00000000_00000000_00000000_00000000
